//--- core_pkg.sv
package core_pkg;

   // ==========================================================
   // Widths
   // ==========================================================
   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int NUM_REGS   = 32;

   // ==========================================================
   // Encodings
   // ==========================================================
   typedef enum logic [6:0] {
      OP_IMM = 7'b0010011,
      OP     = 7'b0110011,
      LUI    = 7'b0110111,
      AUIPC  = 7'b0010111,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111,
      BRANCH = 7'b1100011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      SYSTEM = 7'b1110011
   } opcode_e;

   typedef enum logic [2:0] {
      FMT_NONE, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_R
   } format_e;

   typedef enum logic [4:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
      ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
      ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
      ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
      ALU_NOP
   } alu_op_e;

   // ==========================================================
   // Stage bundles
   // ==========================================================
   typedef struct packed {
      logic [XLEN-1:0]       pc;
      logic [XLEN-1:0]       instr;
      alu_op_e               alu_op;
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       rs1_data;
      logic [XLEN-1:0]       rs2_data;
      logic [XLEN-1:0]       imm;
      logic                  use_imm;
      logic                  rf_wr_en;
      logic                  illegal;
   } id_bus_t;

   typedef struct packed {
      logic [XLEN-1:0]       pc;
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       rd_res;
      logic                  rf_wr_en;
      logic [XLEN-1:0]       next_pc;
      logic                  is_branch;
      logic                  taken;
      logic                  illegal;
   } ex_bus_t;

   // Report handed to the host for each retired instruction.
   typedef struct packed {
      logic [XLEN-1:0]       pc;
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       rd_res;
      logic                  wr_en;
      logic [XLEN-1:0]       next_pc;
      logic                  taken;
      logic                  illegal;
   } retire_t;

endpackage

//--- imm_generator.sv
`timescale 1ns/1ps

module imm_generator (
   input  logic [core_pkg::XLEN-1:0] instr_i,
   input  core_pkg::format_e         format_i,
   output logic [core_pkg::XLEN-1:0] imm_o
);
   import core_pkg::*;

   logic sign;

   assign sign = instr_i[31];

   always_comb begin
      case (format_i)
         FMT_I: imm_o = {{20{sign}}, instr_i[31:20]};
         FMT_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
         FMT_B: begin
            imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};                     // Halfword offset.
         end
         FMT_U: imm_o = {instr_i[31:12], 12'b0};
         FMT_J: begin
            imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
         end
         default: imm_o = '0;                                  // R type and none.
      endcase
   end

endmodule

//--- regfile_2r1w.sv
`timescale 1ns/1ps

module regfile_2r1w (
   input  logic                            clk,
   input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
   input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
   input  logic                            wen_i,
   input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
   input  logic [core_pkg::XLEN-1:0]       wdata_i,
   output logic [core_pkg::XLEN-1:0]       rdata_a_o,
   output logic [core_pkg::XLEN-1:0]       rdata_b_o
);
   import core_pkg::*;

   logic [XLEN-1:0] regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (wen_i && (waddr_i != '0)) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // x0 is never stored, so force it on the read side.
   assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
   assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- decoder.sv
`timescale 1ns/1ps

module decoder (
   input  logic                            clk,
   input  logic                            rst_n_i,
   input  logic                            instr_req_i,
   input  logic [core_pkg::XLEN-1:0]       instr_i,
   input  logic [core_pkg::XLEN-1:0]       pc_i,
   input  logic                            wb_en_i,
   input  logic [core_pkg::REG_ADDR_W-1:0] wb_addr_i,
   input  logic [core_pkg::XLEN-1:0]       wb_data_i,
   input  logic                            retire_done_i,
   output logic                            instr_ack_o,
   output logic                            id_valid_o,
   output core_pkg::id_bus_t               id_bus_o
);
   import core_pkg::*;

   typedef enum logic {IDLE, BUSY} state_e;

   state_e          state_q;
   opcode_e         opcode;
   format_e         format;
   alu_op_e         alu_op;
   logic            use_imm;
   logic            rf_wr_en;
   logic            illegal;
   logic            accept;
   logic [XLEN-1:0] imm;
   logic [XLEN-1:0] rs1_data;
   logic [XLEN-1:0] rs2_data;

   function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
      alu_op_e op;
      case (funct3)
         3'b000:  op = alt ? ALU_SUB : ALU_ADD;
         3'b001:  op = ALU_SLL;
         3'b010:  op = ALU_SLT;
         3'b011:  op = ALU_SLTU;
         3'b100:  op = ALU_XOR;
         3'b101:  op = alt ? ALU_SRA : ALU_SRL;
         3'b110:  op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   imm_generator u_imm_gen (
      .instr_i  (instr_i),
      .format_i (format),
      .imm_o    (imm)
   );

   regfile_2r1w u_regfile (
      .clk       (clk),
      .raddr_a_i (instr_i[19:15]),
      .raddr_b_i (instr_i[24:20]),
      .wen_i     (wb_en_i),
      .waddr_i   (wb_addr_i),
      .wdata_i   (wb_data_i),
      .rdata_a_o (rs1_data),
      .rdata_b_o (rs2_data)
   );

   // ==========================================================
   // Opcode decode
   // ==========================================================
   assign opcode = opcode_e'(instr_i[6:0]);

   always_comb begin
      format   = FMT_NONE;
      alu_op   = ALU_NOP;
      use_imm  = 1'b0;
      rf_wr_en = 1'b0;
      illegal  = 1'b0;
      case (opcode)
         OP_IMM: begin
            format   = FMT_I;
            alu_op   = arith_op(instr_i[14:12], instr_i[30] && (instr_i[14:12] == 3'b101));
            use_imm  = 1'b1;
            rf_wr_en = 1'b1;
         end
         OP: begin
            format   = FMT_R;
            alu_op   = arith_op(instr_i[14:12], instr_i[30]);
            rf_wr_en = 1'b1;
         end
         LUI, AUIPC: begin
            format   = FMT_U;
            alu_op   = (opcode == LUI) ? ALU_LUI : ALU_AUIPC;
            use_imm  = 1'b1;
            rf_wr_en = 1'b1;
         end
         JAL: begin
            format   = FMT_J;
            alu_op   = ALU_JAL;
            rf_wr_en = 1'b1;
         end
         JALR: begin
            format   = FMT_I;
            alu_op   = ALU_JALR;
            use_imm  = 1'b1;
            rf_wr_en = 1'b1;
         end
         BRANCH: begin
            format = FMT_B;
            case (instr_i[14:12])
               3'b000:  alu_op = ALU_BEQ;
               3'b001:  alu_op = ALU_BNE;
               3'b100:  alu_op = ALU_BLT;
               3'b101:  alu_op = ALU_BGE;
               3'b110:  alu_op = ALU_BLTU;
               3'b111:  alu_op = ALU_BGEU;
               default: illegal = 1'b1;                        // funct3 010 and 011.
            endcase
         end
         LOAD:    begin format = FMT_I; illegal = 1'b1; end
         STORE:   begin format = FMT_S; illegal = 1'b1; end
         default: illegal = 1'b1;                              // SYSTEM and unknown.
      endcase
   end

   // ==========================================================
   // Input handshake and in-flight tracking
   // ==========================================================
   assign accept = (state_q == IDLE) && !instr_ack_o && instr_req_i;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q     <= IDLE;
         instr_ack_o <= 1'b0;
         id_valid_o  <= 1'b0;
      end else begin
         id_valid_o <= accept;
         if (accept) begin
            state_q     <= BUSY;
            instr_ack_o <= 1'b1;
         end else begin
            if (instr_ack_o && !instr_req_i) instr_ack_o <= 1'b0;
            if ((state_q == BUSY) && retire_done_i) state_q <= IDLE;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         id_bus_o.pc       <= pc_i;
         id_bus_o.instr    <= instr_i;
         id_bus_o.alu_op   <= alu_op;
         id_bus_o.rd       <= rf_wr_en ? instr_i[11:7] : '0;   // No target, report x0.
         id_bus_o.rs1_data <= rs1_data;
         id_bus_o.rs2_data <= rs2_data;
         id_bus_o.imm      <= imm;
         id_bus_o.use_imm  <= use_imm;
         id_bus_o.rf_wr_en <= rf_wr_en && !illegal;
         id_bus_o.illegal  <= illegal;
      end
   end

   a_done_while_busy : assert property (
      @(posedge clk) disable iff (!rst_n_i)
      retire_done_i |-> ((state_q == BUSY) && !id_valid_o)
   ) else $error("Retire completed with no instruction in flight");

endmodule

//--- alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              id_valid_i,
   input  core_pkg::id_bus_t id_bus_i,
   output logic              ex_valid_o,
   output core_pkg::ex_bus_t ex_bus_o
);
   import core_pkg::*;

   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] pc_plus4;
   logic [XLEN-1:0] pc_target;
   logic [XLEN-1:0] jalr_sum;
   logic [XLEN-1:0] alu_res;
   logic [XLEN-1:0] next_pc;
   logic [4:0]      shamt;
   logic            lt_s;
   logic            lt_u;
   logic            is_branch;
   logic            taken;

   assign op_a      = id_bus_i.rs1_data;
   assign op_b      = id_bus_i.use_imm ? id_bus_i.imm : id_bus_i.rs2_data;
   assign shamt     = op_b[4:0];
   assign lt_s      = $signed(op_a) < $signed(op_b);
   assign lt_u      = op_a < op_b;
   assign pc_plus4  = id_bus_i.pc + 32'd4;
   assign pc_target = id_bus_i.pc + id_bus_i.imm;
   assign jalr_sum  = op_a + id_bus_i.imm;

   // ==========================================================
   // ALU and branch compare
   // ==========================================================
   always_comb begin
      case (id_bus_i.alu_op)
         ALU_ADD:           alu_res = op_a + op_b;
         ALU_SUB:           alu_res = op_a - op_b;
         ALU_SLL:           alu_res = op_a << shamt;
         ALU_SLT:           alu_res = {{(XLEN-1){1'b0}}, lt_s};
         ALU_SLTU:          alu_res = {{(XLEN-1){1'b0}}, lt_u};
         ALU_XOR:           alu_res = op_a ^ op_b;
         ALU_SRL:           alu_res = op_a >> shamt;
         ALU_SRA:           alu_res = $unsigned($signed(op_a) >>> shamt);
         ALU_OR:            alu_res = op_a | op_b;
         ALU_AND:           alu_res = op_a & op_b;
         ALU_LUI:           alu_res = id_bus_i.imm;
         ALU_AUIPC:         alu_res = pc_target;
         ALU_JAL, ALU_JALR: alu_res = pc_plus4;                // Link value.
         default:           alu_res = '0;
      endcase
   end

   always_comb begin
      is_branch = 1'b1;
      taken     = 1'b0;
      case (id_bus_i.alu_op)
         ALU_BEQ:  taken = (op_a == op_b);
         ALU_BNE:  taken = (op_a != op_b);
         ALU_BLT:  taken = lt_s;
         ALU_BGE:  taken = !lt_s;
         ALU_BLTU: taken = lt_u;
         ALU_BGEU: taken = !lt_u;
         default:  is_branch = 1'b0;
      endcase
   end

   always_comb begin
      if (taken || (id_bus_i.alu_op == ALU_JAL)) begin
         next_pc = pc_target;
      end else if (id_bus_i.alu_op == ALU_JALR) begin
         next_pc = {jalr_sum[XLEN-1:1], 1'b0};
      end else begin
         next_pc = pc_plus4;
      end
   end

   // ==========================================================
   // Execute register
   // ==========================================================
   always_ff @(posedge clk) begin
      if (!rst_n_i) ex_valid_o <= 1'b0;
      else          ex_valid_o <= id_valid_i;
   end

   always_ff @(posedge clk) begin
      if (id_valid_i) begin
         ex_bus_o.pc        <= id_bus_i.pc;
         ex_bus_o.rd        <= id_bus_i.rd;
         ex_bus_o.rd_res    <= alu_res;
         ex_bus_o.rf_wr_en  <= id_bus_i.rf_wr_en;
         ex_bus_o.next_pc   <= next_pc;
         ex_bus_o.is_branch <= is_branch;
         ex_bus_o.taken     <= taken;                          // Conditional branches only.
         ex_bus_o.illegal   <= id_bus_i.illegal;
      end
   end

   a_branch_no_write : assert property (
      @(posedge clk) disable iff (!rst_n_i)
      (id_valid_i && is_branch) |=> (ex_valid_o && !ex_bus_o.rf_wr_en)
   ) else $error("Branch carries a register write");

endmodule

//--- writeback_retire.sv
`timescale 1ns/1ps

module writeback_retire (
   input  logic                            clk,
   input  logic                            rst_n_i,
   input  logic                            ex_valid_i,
   input  core_pkg::ex_bus_t               ex_bus_i,
   input  logic                            ret_ack_i,
   output logic                            wb_en_o,
   output logic [core_pkg::REG_ADDR_W-1:0] wb_addr_o,
   output logic [core_pkg::XLEN-1:0]       wb_data_o,
   output logic                            ret_req_o,
   output core_pkg::retire_t               ret_o,
   output logic                            retire_done_o
);
   import core_pkg::*;

   typedef enum logic [1:0] {WAIT, REQ, ACK} state_e;

   state_e state_q;
   logic   take;

   assign take = ex_valid_i && (state_q == WAIT);

   // Single write in the cycle the execute bundle arrives.
   assign wb_en_o   = take && ex_bus_i.rf_wr_en && (ex_bus_i.rd != '0);
   assign wb_addr_o = ex_bus_i.rd;
   assign wb_data_o = ex_bus_i.rd_res;

   assign ret_req_o = (state_q == REQ);

   // ==========================================================
   // Output handshake
   // ==========================================================
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q       <= WAIT;
         retire_done_o <= 1'b0;
      end else begin
         retire_done_o <= 1'b0;
         case (state_q)
            WAIT: if (take) state_q <= REQ;
            REQ:  if (ret_ack_i) state_q <= ACK;
            ACK: begin
               if (!ret_ack_i) begin
                  state_q       <= WAIT;
                  retire_done_o <= 1'b1;                       // Frees the decoder.
               end
            end
            default: state_q <= WAIT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         ret_o.pc      <= ex_bus_i.pc;
         ret_o.rd      <= ex_bus_i.rd;
         ret_o.rd_res  <= ex_bus_i.rd_res;
         ret_o.wr_en   <= ex_bus_i.rf_wr_en;
         ret_o.next_pc <= ex_bus_i.next_pc;
         ret_o.taken   <= ex_bus_i.taken;
         ret_o.illegal <= ex_bus_i.illegal;
      end
   end

   a_no_overrun : assert property (
      @(posedge clk) disable iff (!rst_n_i)
      ex_valid_i |-> (state_q == WAIT)
   ) else $error("Execute bundle arrived while a report was still pending");

endmodule

//--- core_top.sv
`timescale 1ns/1ps

module core_top (
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  logic                      instr_req_i,
   input  logic [core_pkg::XLEN-1:0] instr_i,
   input  logic [core_pkg::XLEN-1:0] pc_i,
   input  logic                      ret_ack_i,
   output logic                      instr_ack_o,
   output logic                      ret_req_o,
   output core_pkg::retire_t         ret_o
);
   import core_pkg::*;

   logic                  id_valid;
   id_bus_t               id_bus;
   logic                  ex_valid;
   ex_bus_t               ex_bus;
   logic                  wb_en;
   logic [REG_ADDR_W-1:0] wb_addr;
   logic [XLEN-1:0]       wb_data;
   logic                  retire_done;

   decoder u_decoder (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .instr_req_i   (instr_req_i),
      .instr_i       (instr_i),
      .pc_i          (pc_i),
      .wb_en_i       (wb_en),
      .wb_addr_i     (wb_addr),
      .wb_data_i     (wb_data),
      .retire_done_i (retire_done),
      .instr_ack_o   (instr_ack_o),
      .id_valid_o    (id_valid),
      .id_bus_o      (id_bus)
   );

   alu_execute u_execute (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .id_valid_i (id_valid),
      .id_bus_i   (id_bus),
      .ex_valid_o (ex_valid),
      .ex_bus_o   (ex_bus)
   );

   writeback_retire u_retire (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .ex_valid_i    (ex_valid),
      .ex_bus_i      (ex_bus),
      .ret_ack_i     (ret_ack_i),
      .wb_en_o       (wb_en),
      .wb_addr_o     (wb_addr),
      .wb_data_o     (wb_data),
      .ret_req_o     (ret_req_o),
      .ret_o         (ret_o),
      .retire_done_o (retire_done)
   );

endmodule

//--- tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// Architectural register state as the host sees it.
logic [31:0] rf_mirror [32];

function automatic void mirror_clear();
   for (int i = 0; i < 32; i++) begin
      rf_mirror[i] = '0;
   end
endfunction

function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
   logic [31:0] r;
   logic [4:0]  sh;
   sh = b[4:0];                                                // Shift amount.
   case (f3)
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << sh;
      3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    r = (a < b) ? 32'd1 : 32'd0;
      3'd4:    r = a ^ b;
      3'd5:    r = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
      3'd6:    r = a | b;
      default: r = a & b;
   endcase
   return r;
endfunction

function automatic retire_t model_expect(input logic [31:0] ins, input logic [31:0] pc);
   retire_t     res;
   logic [2:0]  f3;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] imm_i;
   logic [31:0] imm_b;
   logic [31:0] imm_u;
   logic [31:0] imm_j;
   logic        wr;
   f3    = ins[14:12];
   a     = rf_mirror[ins[19:15]];
   b     = rf_mirror[ins[24:20]];
   imm_i = {{20{ins[31]}}, ins[31:20]};
   imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
   imm_u = {ins[31:12], 12'h000};
   imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
   wr    = 1'b0;
   res   = '0;
   res.pc      = pc;
   res.next_pc = pc + 32'd4;
   case (ins[6:0])
      7'h13: begin
         wr         = 1'b1;
         res.rd_res = model_alu(f3, ins[30] && (f3 == 3'd5), a, imm_i);   // SRAI only.
      end
      7'h33: begin
         wr         = 1'b1;
         res.rd_res = model_alu(f3, ins[30], a, b);
      end
      7'h37: begin
         wr         = 1'b1;
         res.rd_res = imm_u;
      end
      7'h17: begin
         wr         = 1'b1;
         res.rd_res = pc + imm_u;
      end
      7'h6f: begin
         wr          = 1'b1;
         res.rd_res  = pc + 32'd4;
         res.next_pc = pc + imm_j;
      end
      7'h67: begin
         wr          = 1'b1;
         res.rd_res  = pc + 32'd4;
         res.next_pc = (a + imm_i) & ~32'd1;
      end
      7'h63: begin
         case (f3)
            3'd0:    res.taken = (a == b);
            3'd1:    res.taken = (a != b);
            3'd4:    res.taken = ($signed(a) < $signed(b));
            3'd5:    res.taken = ($signed(a) >= $signed(b));
            3'd6:    res.taken = (a < b);
            3'd7:    res.taken = (a >= b);
            default: res.illegal = 1'b1;
         endcase
         if (res.taken) res.next_pc = pc + imm_b;
      end
      default: res.illegal = 1'b1;                             // LOAD, STORE, SYSTEM, unknown.
   endcase
   res.wr_en = wr;
   res.rd    = wr ? ins[11:7] : 5'd0;
   return res;
endfunction

function automatic void mirror_commit(input retire_t res);
   if (res.wr_en && (res.rd != 5'd0)) rf_mirror[res.rd] = res.rd_res;
endfunction

`endif

//--- tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top;
   import core_pkg::*;

   localparam int NUM_RANDOM = 400;
   localparam int WAIT_LIMIT = 50;

   logic        clk;
   logic        rst_n;
   logic        instr_req;
   logic [31:0] instr;
   logic [31:0] pc;
   logic        ret_ack;
   logic        instr_ack;
   logic        ret_req;
   retire_t     ret;

   integer      seed;
   int          cycle;
   int          ack_cycle;
   int          ack_count;
   int          ret_count;
   int          issued;
   logic [4:0]  prev_rd;
   logic        ack_prev;
   logic        req_prev;
   retire_t     ret_prev;

   `include "tb_rv_model.svh"

   core_top u_dut (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .instr_req_i (instr_req),
      .instr_i     (instr),
      .pc_i        (pc),
      .ret_ack_i   (ret_ack),
      .instr_ack_o (instr_ack),
      .ret_req_o   (ret_req),
      .ret_o       (ret)
   );

   always #20 clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   task automatic halt_with_failure();
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      assert (got === want) else begin
         $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, want);
         halt_with_failure();
      end
   endtask

   // ==========================================================
   // Random stimulus
   // ==========================================================
   function automatic logic [31:0] next_random();
      return $random(seed);
   endfunction

   function automatic int unsigned pick(input int unsigned n);
      logic [31:0] r;
      r = next_random();
      return r % n;
   endfunction

   function automatic logic [31:0] random_pc();
      logic [31:0] w;
      w = next_random();
      return {w[31:2], 2'b00};                                 // Word aligned.
   endfunction

   function automatic logic [2:0] branch_funct3();
      case (pick(6))
         0:       return 3'b000;
         1:       return 3'b001;
         2:       return 3'b100;
         3:       return 3'b101;
         4:       return 3'b110;
         default: return 3'b111;
      endcase
   endfunction

   function automatic logic [6:0] unknown_opcode(input logic [6:0] op);
      case (op)
         7'h13, 7'h33, 7'h37, 7'h17, 7'h6f, 7'h67, 7'h63: return 7'h0b;
         default: return op;
      endcase
   endfunction

   function automatic logic [31:0] make_instr();
      logic [31:0] w;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      int unsigned kind;
      w    = next_random();
      kind = pick(16);
      rs1  = (pick(4) == 0) ? prev_rd : w[19:15];              // Depend on the last result.
      rs2  = (pick(8) == 0) ? rs1 : w[24:20];                  // Equal operands now and then.
      f3   = w[14:12];
      w[19:15] = rs1;
      w[24:20] = rs2;
      case (kind)
         0, 1, 2, 3: begin
            w[6:0] = 7'h13;
            if (f3 == 3'b001) w[31:25] = 7'h00;
            if (f3 == 3'b101) w[31:25] = {1'b0, w[30], 5'b00000};
         end
         4, 5, 6: begin
            w[6:0]   = 7'h33;
            w[31:25] = ((f3 == 3'b000) || (f3 == 3'b101)) ? {1'b0, w[30], 5'b00000} : 7'h00;
         end
         7:  w[6:0] = 7'h37;
         8:  w[6:0] = 7'h17;
         9:  w[6:0] = 7'h6f;
         10: begin
            w[6:0]   = 7'h67;
            w[14:12] = 3'b000;
         end
         11, 12, 13: begin
            w[6:0]   = 7'h63;
            w[14:12] = branch_funct3();
         end
         default: begin
            case (pick(5))
               0:       w[6:0] = 7'h03;
               1:       w[6:0] = 7'h23;
               2:       w[6:0] = 7'h73;
               3:       w[6:0] = unknown_opcode(w[6:0]);
               default: begin
                  w[6:0]   = 7'h63;
                  w[14:13] = 2'b01;                            // Reserved branch funct3.
               end
            endcase
         end
      endcase
      prev_rd = w[11:7];
      return w;
   endfunction

   // ==========================================================
   // Host side of both handshakes
   // ==========================================================
   task automatic wait_level(input bit on_ret, input logic level);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (((on_ret ? ret_req : instr_ack) !== level) && (n < WAIT_LIMIT));
      assert ((on_ret ? ret_req : instr_ack) === level) else begin
         if (on_ret) begin
            $display("Timeout: retire handshake stalled, ret_req_o never went to %0b", level);
         end else begin
            $display("Timeout: instruction handshake stalled, instr_ack_o never went to %0b",
                     level);
         end
         halt_with_failure();
      end
   endtask

   task automatic compare_report(input retire_t want);
      check_field("ret_o.pc", ret.pc, want.pc);
      check_field("ret_o.rd", 32'(ret.rd), 32'(want.rd));
      check_field("ret_o.rd_res", ret.rd_res, want.rd_res);
      check_field("ret_o.wr_en", 32'(ret.wr_en), 32'(want.wr_en));
      check_field("ret_o.next_pc", ret.next_pc, want.next_pc);
      check_field("ret_o.taken", 32'(ret.taken), 32'(want.taken));
      check_field("ret_o.illegal", 32'(ret.illegal), 32'(want.illegal));
   endtask

   task automatic run_instr(input logic [31:0] ins, input logic [31:0] ins_pc);
      retire_t want;
      want = model_expect(ins, ins_pc);
      repeat (pick(4)) @(posedge clk);
      @(posedge clk);
      instr     <= ins;
      pc        <= ins_pc;
      instr_req <= 1'b1;
      wait_level(1'b0, 1'b1);
      repeat (pick(4)) @(posedge clk);
      @(posedge clk);
      instr_req <= 1'b0;
      wait_level(1'b0, 1'b0);
      wait_level(1'b1, 1'b1);
      compare_report(want);
      mirror_commit(want);
      repeat (pick(4)) @(posedge clk);
      @(posedge clk);
      ret_ack <= 1'b1;
      wait_level(1'b1, 1'b0);
      repeat (pick(4)) @(posedge clk);
      @(posedge clk);
      ret_ack <= 1'b0;
      issued++;
   endtask

   task automatic fill_registers();
      logic [31:0] w;
      for (int r = 1; r < 32; r++) begin
         w = next_random();
         run_instr({w[31:12], 5'(r), 7'h37}, random_pc());               // LUI.
         w = next_random();
         run_instr({w[31:20], 5'(r), 3'b000, 5'(r), 7'h13}, random_pc()); // ADDI.
      end
   endtask

   task automatic read_back_registers();
      for (int r = 1; r < 32; r++) begin
         run_instr({12'h000, 5'(r), 3'b000, 5'd0, 7'h13}, random_pc());   // ADDI x0.
      end
   endtask

   // ==========================================================
   // Protocol monitor
   // ==========================================================
   always @(negedge clk) begin
      if (rst_n) begin
         if (instr_ack && !ack_prev) begin
            ack_cycle = cycle;
            ack_count++;
         end
         if (ret_req && !req_prev) begin
            ret_count++;
            assert (cycle - ack_cycle == 2) else begin
               $display("Mismatch at %0t ns: ret_req_o delay got %0d, expected %0d",
                        $time, cycle - ack_cycle, 2);
               halt_with_failure();
            end
            assert (ret_count == ack_count) else begin
               $display("Report %0d arrived with only %0d accepted instructions",
                        ret_count, ack_count);
               halt_with_failure();
            end
         end
         if (ret_req && req_prev) begin
            assert (ret === ret_prev) else begin
               $display("Mismatch at %0t ns: ret_o got %h, expected %h", $time, ret, ret_prev);
               halt_with_failure();
            end
         end
      end
      ack_prev = instr_ack;
      req_prev = ret_req;
      ret_prev = ret;
   end

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      instr_req = 1'b0;
      instr     = '0;
      pc        = '0;
      ret_ack   = 1'b0;
      seed      = 32'hebed6527;
      prev_rd   = '0;
      mirror_clear();
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      assert ((ret_req === 1'b0) && (instr_ack === 1'b0)) else begin
         $display("Handshake outputs were not low after reset at %0t ns", $time);
         halt_with_failure();
      end
      fill_registers();
      for (int i = 0; i < NUM_RANDOM; i++) begin
         run_instr(make_instr(), random_pc());
      end
      read_back_registers();
      @(negedge clk);
      if ((ack_count == issued) && (ret_count == issued)) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         $display("Counted %0d accepts and %0d reports for %0d instructions",
                  ack_count, ret_count, issued);
         halt_with_failure();
      end
   end

endmodule

//--- flist.f
+incdir+.
core_pkg.sv
imm_generator.sv
regfile_2r1w.sv
decoder.sv
alu_execute.sv
writeback_retire.sv
core_top.sv
tb_core_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_core_top -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_core_top
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

echo "Simulation finished"
exit 0
